// File: hw/mr_pkg.sv
/*
 * Frame wrapper shared definitions
 * Port widths, OSD status bit positions and the user-port word views
 */

package mr_pkg;

    // Host status word
    localparam int status_w = 64;

    // DDR port
    localparam int ddr_aw  = 29;
    localparam int ddr_dw  = 64;
    localparam int burst_w = 8;
    localparam int be_w    = ddr_dw / 8;

    // User port and OSD menu
    localparam int user_w = 7;
    localparam int menu_w = 16;

    // Horizontal scaling for CRT
    localparam int st_hsize_en  = 19;
    localparam int st_hsize_lsb = 20;

    // Screen position offsets
    localparam int st_hofs_lsb = 24;
    localparam int st_vofs_lsb = 28;

    // User port modes
    localparam int st_db15 = 37;
    localparam int st_uart = 38;

    // Rotation options overlap the UART enable bit
    localparam int st_flip_lsb = 38;

    // Serial view of the user port
    typedef struct packed {
        logic [user_w-3:0] spare;
        logic              rx;
        logic              tx;
    } uart_view_t;

    // Same seven pins, read as joystick lines or as a serial link
    typedef union packed {
        logic [user_w-1:0] db15;
        uart_view_t        uart;
    } user_port_t;

endpackage

// File: hw/ddr_port_if.sv
/*
 * DDR requester port
 * Burst request signals with a busy back-pressure line
 */

interface ddr_port_if;
    import mr_pkg::*;

    logic [burst_w-1:0] burstcnt;
    logic [ddr_aw-1:0]  addr;
    logic               rd;
    logic               we;
    logic [be_w-1:0]    be;
    logic               busy;

    // Seen from the block that issues requests
    modport requester (
        output burstcnt, addr, rd, we, be,
        input  busy
    );

    // Seen from the arbiter
    modport grant (
        input  burstcnt, addr, rd, we, be,
        output busy
    );

endinterface

// File: hw/osd_status_decode.sv
/*
 * OSD status decoder
 * Registers the configuration fields of the host status word
 * and builds the mask that hides OSD menu entries
 */

module osd_status_decode #(
    parameter int rotate_opts = 0
) (
    input  logic                        clk_sys,
    input  logic                        reset,
    input  logic [mr_pkg::status_w-1:0] status,
    input  logic [6:0]                  core_mod,
    input  logic                        direct_video,
    output logic [3:0]                  hoffset,
    output logic [3:0]                  voffset,
    output logic                        hsize_enable,
    output logic [3:0]                  hsize_scale,
    output logic                        uart_en,
    output logic                        db15_en,
    output logic                        framebuf_flip,
    output logic [mr_pkg::menu_w-1:0]   menumask
);
    import mr_pkg::*;

    logic [menu_w-1:0] mask_next;

    // A high mask bit hides the menu item
    always_comb begin
        mask_next    = '0;
        mask_next[0] = direct_video;
        mask_next[2] = ~status[st_hsize_en];
        if (rotate_opts != 0) begin
            // Extra rotate entries shown for vertical games
            mask_next[4] = ~core_mod[0];
            mask_next[1] = 1'b1;
        end else begin
            mask_next[4] = 1'b1;
            mask_next[1] = ~core_mod[0];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hoffset       <= '0;
            voffset       <= '0;
            hsize_enable  <= 1'b0;
            hsize_scale   <= '0;
            uart_en       <= 1'b0;
            db15_en       <= 1'b0;
            framebuf_flip <= 1'b0;
            menumask      <= '0;
        end else begin
            hoffset       <= status[st_hofs_lsb +: 4];
            voffset       <= status[st_vofs_lsb +: 4];
            hsize_enable  <= status[st_hsize_en];
            hsize_scale   <= status[st_hsize_lsb +: 4];
            uart_en       <= status[st_uart];
            db15_en       <= status[st_db15];
            // Rotation field value two selects the flipped frame buffer
            framebuf_flip <= status[st_flip_lsb +: 2] == 2'd2;
            menumask      <= mask_next;
        end
    end

endmodule

// File: hw/user_port_mux.sv
/*
 * User port driver
 * Drives the 7-pin port as DB15 joystick, UART or idle lines
 */

module user_port_mux (
    input  logic               clk_sys,
    input  logic               reset,
    input  logic               db15_en,
    input  logic               uart_en,
    input  mr_pkg::user_port_t db15_word,
    input  logic               uart_tx,
    input  logic               game_tx,
    input  mr_pkg::user_port_t user_in,
    output mr_pkg::user_port_t user_out,
    output logic               game_rx
);
    import mr_pkg::*;

    user_port_t drive;

    // DB15 wins over UART, idle lines float high
    always_comb begin
        drive.db15 = '1;
        if (db15_en) begin
            drive = db15_word;
        end else if (uart_en) begin
            // Core and cheat UARTs share the tx line
            drive.uart.tx = uart_tx & game_tx;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            user_out.db15 <= '1;
        end else begin
            user_out <= drive;
        end
    end

    // Receive line idles high when the UART is off
    assign game_rx = uart_en ? user_in.uart.rx : 1'b1;

endmodule

// File: hw/ddr_arbiter.sv
/*
 * DDR port arbiter
 * Shares one DDR port between the ROM loader and the rotation buffer,
 * switching only once read data in flight has come back
 */

module ddr_arbiter (
    input  logic                       clk_sys,
    input  logic                       reset,
    input  logic                       downloading,
    ddr_port_if.grant                  ld,
    ddr_port_if.grant                  rot,
    input  logic                       ddr_busy,
    input  logic                       ddr_dout_ready,
    output logic [mr_pkg::burst_w-1:0] ddr_burstcnt,
    output logic [mr_pkg::ddr_aw-1:0]  ddr_addr,
    output logic                       ddr_rd,
    output logic                       ddr_we,
    output logic [mr_pkg::be_w-1:0]    ddr_be
);
    import mr_pkg::*;

    // Room for several bursts in flight
    localparam int cnt_w = burst_w + 4;

    logic               grant_ld;
    logic [cnt_w-1:0]   pending;
    logic [cnt_w-1:0]   add_beats;
    logic [cnt_w-1:0]   sub_beats;
    logic               sel_rd;
    logic               sel_we;
    logic               owner_req;
    logic               acc_rd;
    logic               quiet;

    // Request mux from the granted side
    always_comb begin
        if (grant_ld) begin
            ddr_burstcnt = ld.burstcnt;
            ddr_addr     = ld.addr;
            ddr_be       = ld.be;
            sel_rd       = ld.rd;
            sel_we       = ld.we;
        end else begin
            ddr_burstcnt = rot.burstcnt;
            ddr_addr     = rot.addr;
            ddr_be       = rot.be;
            sel_rd       = rot.rd;
            sel_we       = rot.we;
        end
    end

    // No request reaches the memory while in reset
    assign ddr_rd = sel_rd & ~reset;
    assign ddr_we = sel_we & ~reset;

    // The side without the grant is always stalled
    assign ld.busy  = reset | ~grant_ld | ddr_busy;
    assign rot.busy = reset |  grant_ld | ddr_busy;

    assign owner_req = sel_rd | sel_we;
    assign acc_rd    = ddr_rd & ~ddr_busy;
    assign quiet     = (pending == '0) && !owner_req;

    assign add_beats = acc_rd ? cnt_w'(ddr_burstcnt) : '0;
    assign sub_beats = ddr_dout_ready ? cnt_w'(1) : '0;

    // Read beats still owed by the memory
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= pending + add_beats - sub_beats;
        end
    end

    // Loader owns the port during download, rotator otherwise
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            grant_ld <= 1'b0;
        end else if (quiet && (grant_ld != downloading)) begin
            grant_ld <= downloading;
        end
    end

endmodule

// File: hw/mr_frame_top.sv
/*
 * Arcade frame control glue
 * OSD status decode, user-port drive and DDR sharing between
 * the ROM loader and the screen rotator
 */

module mr_frame_top #(
    parameter int rotate_opts = 0
) (
    input  logic                        clk_sys,
    input  logic                        reset,
    // OSD configuration
    input  logic [mr_pkg::status_w-1:0] status,
    input  logic [6:0]                  core_mod,
    input  logic                        direct_video,
    // User port
    input  logic [mr_pkg::user_w-1:0]   db15_word,
    input  logic                        uart_tx,
    input  logic                        game_tx,
    input  logic [mr_pkg::user_w-1:0]   user_in,
    output logic [mr_pkg::user_w-1:0]   user_out,
    output logic                        game_rx,
    output logic                        uart_en,
    output logic                        db15_en,
    // Decoded settings
    output logic [3:0]                  hoffset,
    output logic [3:0]                  voffset,
    output logic                        hsize_enable,
    output logic [3:0]                  hsize_scale,
    output logic                        framebuf_flip,
    output logic [mr_pkg::menu_w-1:0]   menumask,
    input  logic                        downloading,
    // Fast ROM loader
    input  logic [mr_pkg::burst_w-1:0]  ld_burstcnt,
    input  logic [mr_pkg::ddr_aw-1:0]   ld_addr,
    input  logic                        ld_rd,
    input  logic                        ld_we,
    input  logic [mr_pkg::be_w-1:0]     ld_be,
    output logic                        ld_busy,
    // Screen rotation
    input  logic [mr_pkg::burst_w-1:0]  rot_burstcnt,
    input  logic [mr_pkg::ddr_aw-1:0]   rot_addr,
    input  logic                        rot_rd,
    input  logic                        rot_we,
    input  logic [mr_pkg::be_w-1:0]     rot_be,
    output logic                        rot_busy,
    // DDR memory port
    input  logic                        ddr_busy,
    input  logic                        ddr_dout_ready,
    output logic [mr_pkg::burst_w-1:0]  ddr_burstcnt,
    output logic [mr_pkg::ddr_aw-1:0]   ddr_addr,
    output logic                        ddr_rd,
    output logic                        ddr_we,
    output logic [mr_pkg::be_w-1:0]     ddr_be
);

    ddr_port_if ld_port ();
    ddr_port_if rot_port ();

    assign ld_port.burstcnt = ld_burstcnt;
    assign ld_port.addr     = ld_addr;
    assign ld_port.rd       = ld_rd;
    assign ld_port.we       = ld_we;
    assign ld_port.be       = ld_be;
    assign ld_busy          = ld_port.busy;

    assign rot_port.burstcnt = rot_burstcnt;
    assign rot_port.addr     = rot_addr;
    assign rot_port.rd       = rot_rd;
    assign rot_port.we       = rot_we;
    assign rot_port.be       = rot_be;
    assign rot_busy          = rot_port.busy;

    osd_status_decode #(.rotate_opts(rotate_opts)) u_decode (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .status        (status),
        .core_mod      (core_mod),
        .direct_video  (direct_video),
        .hoffset       (hoffset),
        .voffset       (voffset),
        .hsize_enable  (hsize_enable),
        .hsize_scale   (hsize_scale),
        .uart_en       (uart_en),
        .db15_en       (db15_en),
        .framebuf_flip (framebuf_flip),
        .menumask      (menumask)
    );

    // Mode enables come straight from the decoder
    user_port_mux u_user (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .db15_en   (db15_en),
        .uart_en   (uart_en),
        .db15_word (db15_word),
        .uart_tx   (uart_tx),
        .game_tx   (game_tx),
        .user_in   (user_in),
        .user_out  (user_out),
        .game_rx   (game_rx)
    );

    ddr_arbiter u_ddrmux (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .downloading    (downloading),
        .ld             (ld_port.grant),
        .rot            (rot_port.grant),
        .ddr_busy       (ddr_busy),
        .ddr_dout_ready (ddr_dout_ready),
        .ddr_burstcnt   (ddr_burstcnt),
        .ddr_addr       (ddr_addr),
        .ddr_rd         (ddr_rd),
        .ddr_we         (ddr_we),
        .ddr_be         (ddr_be)
    );

endmodule

// File: tests/mr_frame_sva.sv
/*
 * Frame glue checker
 * Reference model of the decoder, user port and DDR sharing rules,
 * compared against the top level through concurrent assertions
 */

module mr_frame_sva #(
    parameter int rotate_opts = 0
) (
    input logic                        clk_sys,
    input logic                        reset,
    input logic [mr_pkg::status_w-1:0] status,
    input logic [6:0]                  core_mod,
    input logic                        direct_video,
    input logic [mr_pkg::user_w-1:0]   db15_word,
    input logic                        uart_tx,
    input logic                        game_tx,
    input logic [mr_pkg::user_w-1:0]   user_in,
    input logic [mr_pkg::user_w-1:0]   user_out,
    input logic                        game_rx,
    input logic                        uart_en,
    input logic                        db15_en,
    input logic [3:0]                  hoffset,
    input logic [3:0]                  voffset,
    input logic                        hsize_enable,
    input logic [3:0]                  hsize_scale,
    input logic                        framebuf_flip,
    input logic [mr_pkg::menu_w-1:0]   menumask,
    input logic                        downloading,
    input logic [mr_pkg::burst_w-1:0]  ld_burstcnt,
    input logic [mr_pkg::ddr_aw-1:0]   ld_addr,
    input logic                        ld_rd,
    input logic                        ld_we,
    input logic [mr_pkg::be_w-1:0]     ld_be,
    input logic                        ld_busy,
    input logic [mr_pkg::burst_w-1:0]  rot_burstcnt,
    input logic [mr_pkg::ddr_aw-1:0]   rot_addr,
    input logic                        rot_rd,
    input logic                        rot_we,
    input logic [mr_pkg::be_w-1:0]     rot_be,
    input logic                        rot_busy,
    input logic                        ddr_busy,
    input logic                        ddr_dout_ready,
    input logic [mr_pkg::burst_w-1:0]  ddr_burstcnt,
    input logic [mr_pkg::ddr_aw-1:0]   ddr_addr,
    input logic                        ddr_rd,
    input logic                        ddr_we,
    input logic [mr_pkg::be_w-1:0]     ddr_be
);
    timeunit 1ns;
    timeprecision 1ns;
    import mr_pkg::*;

    int                errors = 0;
    logic              armed = 1'b0;
    logic [15:0]       exp_fields;
    logic [menu_w-1:0] exp_mask;
    logic [menu_w-1:0] mask_now;
    user_port_t        exp_user;
    user_port_t        user_now;
    user_port_t        in_view;
    logic              g_ld;
    logic [15:0]       pend;
    logic              owner_req;
    logic [46:0]       exp_ddr;

    assign in_view   = user_in;
    assign owner_req = g_ld ? (ld_rd | ld_we) : (rot_rd | rot_we);
    assign exp_ddr   = g_ld ? {ld_burstcnt, ld_addr, ld_rd, ld_we, ld_be}
                            : {rot_burstcnt, rot_addr, rot_rd, rot_we, rot_be};

    always_comb begin
        mask_now    = '0;
        mask_now[0] = direct_video;
        mask_now[2] = ~status[19];
        mask_now[4] = (rotate_opts != 0) ? ~core_mod[0] : 1'b1;
        mask_now[1] = (rotate_opts != 0) ? 1'b1 : ~core_mod[0];
        user_now.db15 = 7'h7f;
        if (db15_en) begin
            user_now.db15 = db15_word;
        end else if (uart_en) begin
            user_now.uart.tx = uart_tx & game_tx;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            armed      <= 1'b1;
            exp_fields <= '0;
            exp_mask   <= '0;
            exp_user   <= 7'h7f;
            g_ld       <= 1'b0;
            pend       <= '0;
        end else begin
            // hoffset, voffset, hsize, scale, uart, db15, flip
            exp_fields <= {status[27:24], status[31:28], status[19], status[23:20],
                           status[38], status[37], status[39:38] == 2'd2};
            exp_mask   <= mask_now;
            exp_user   <= user_now;
            pend       <= pend + ((ddr_rd && !ddr_busy) ? 16'(ddr_burstcnt) : 16'd0)
                               - (ddr_dout_ready ? 16'd1 : 16'd0);
            if (pend == 0 && !owner_req && g_ld != downloading) begin
                g_ld <= downloading;
            end
        end
    end

    status_fields: assert property (@(posedge clk_sys) disable iff (!armed)
        {hoffset, voffset, hsize_enable, hsize_scale, uart_en, db15_en, framebuf_flip}
            == exp_fields)
        else begin
            errors++;
            $error("mismatch status_fields expected %h actual %h", exp_fields,
                   {hoffset, voffset, hsize_enable, hsize_scale, uart_en, db15_en,
                    framebuf_flip});
        end

    menu_mask: assert property (@(posedge clk_sys) disable iff (!armed)
        menumask == exp_mask)
        else begin
            errors++;
            $error("mismatch menu_mask expected %h actual %h", exp_mask, menumask);
        end

    user_drive: assert property (@(posedge clk_sys) disable iff (!armed)
        user_out == exp_user)
        else begin
            errors++;
            $error("mismatch user_drive expected %h actual %h", exp_user, user_out);
        end

    uart_rx: assert property (@(posedge clk_sys) disable iff (!armed)
        game_rx == (uart_en ? in_view.uart.rx : 1'b1))
        else begin
            errors++;
            $error("mismatch uart_rx expected %b actual %b",
                   uart_en ? in_view.uart.rx : 1'b1, game_rx);
        end

    reset_quiet: assert property (@(posedge clk_sys) reset |-> !ddr_rd && !ddr_we)
        else begin
            errors++;
            $error("DDR request driven while reset is high");
        end

    // Loser stalled, owner sees the memory back-pressure
    busy_split: assert property (@(posedge clk_sys) disable iff (reset || !armed)
        {ld_busy, rot_busy} == (g_ld ? {ddr_busy, 1'b1} : {1'b1, ddr_busy}))
        else begin
            errors++;
            $error("mismatch busy_split expected %b actual %b",
                   g_ld ? {ddr_busy, 1'b1} : {1'b1, ddr_busy}, {ld_busy, rot_busy});
        end

    ddr_route: assert property (@(posedge clk_sys) disable iff (reset || !armed)
        {ddr_burstcnt, ddr_addr, ddr_rd, ddr_we, ddr_be} == exp_ddr)
        else begin
            errors++;
            $error("mismatch ddr_route expected %h actual %h", exp_ddr,
                   {ddr_burstcnt, ddr_addr, ddr_rd, ddr_we, ddr_be});
        end

    stall_hold: assert property (@(posedge clk_sys) disable iff (reset || !armed)
        ((ddr_rd || ddr_we) && ddr_busy) |=> (ddr_rd || ddr_we) && $stable(ddr_addr))
        else begin
            errors++;
            $error("stalled DDR request was dropped before busy fell");
        end

endmodule

bind mr_frame_top mr_frame_sva #(.rotate_opts(rotate_opts)) sva_inst (.*);

// File: tests/mr_frame_tb.sv
/*
 * Frame glue testbench
 * Random status, user-port and DDR traffic; checking lives in the bound SVA
 */

module mr_frame_tb;
    timeunit 1ns;
    timeprecision 1ns;

    logic        clk_sys = 1'b0;
    logic        reset;
    logic [63:0] status;
    logic [6:0]  core_mod;
    logic        direct_video, uart_tx, game_tx, downloading;
    logic [6:0]  db15_word, user_in, user_out;
    logic        game_rx, uart_en, db15_en, hsize_enable, framebuf_flip;
    logic [3:0]  hoffset, voffset, hsize_scale;
    logic [15:0] menumask;
    logic [7:0]  ld_burstcnt, rot_burstcnt, ddr_burstcnt, ld_be, rot_be, ddr_be;
    logic [28:0] ld_addr, rot_addr, ddr_addr;
    logic        ld_rd, ld_we, ld_busy, rot_rd, rot_we, rot_busy;
    logic        ddr_busy, ddr_dout_ready, ddr_rd, ddr_we;
    int          seed = 32'hd8fb_20d6;
    int          owed;
    logic        ld_take, rot_take;

    mr_frame_top mr_frame_top_inst (.*);

    always #50 clk_sys = ~clk_sys;

    // First assertion failure ends the run
    always @(posedge clk_sys) begin
        if (mr_frame_top_inst.sva_inst.errors != 0) begin
            $display("Test failed");
            $fatal(1, "an assertion in the checker fired");
        end
    end

    initial begin
        #(2 * 1416 * 100);
        $display("Test failed");
        $fatal(1, "simulation ran past its time limit");
    end

    task automatic next_cycle();
        @(posedge clk_sys);
        #10;
    endtask

    task automatic status_phase();
        for (int i = 0; i < 400; i++) begin
            next_cycle();
            status       = {$random(seed), $random(seed)};
            core_mod     = 7'($random(seed));
            direct_video = 1'($random(seed));
        end
    endtask

    // Cycles through DB15, UART and idle modes
    task automatic user_phase();
        int mode;
        for (int i = 0; i < 400; i++) begin
            next_cycle();
            mode        = i / 134;
            status[37]  = (mode == 0);
            status[38]  = (mode == 1);
            db15_word   = 7'($random(seed));
            user_in     = 7'($random(seed));
            uart_tx     = 1'($random(seed));
            game_tx     = 1'($random(seed));
        end
    endtask

    // Draws a new request or leaves the port idle about half the time
    task automatic new_request(output logic rd, output logic we, output logic [7:0] bc,
                               output logic [28:0] addr, output logic [7:0] be);
        int r;
        r    = $random(seed);
        rd   = (r[1:0] == 2'd1);
        we   = (r[1:0] == 2'd2);
        bc   = 8'(r[3:2]) + 8'd1;
        addr = 29'($random(seed));
        be   = 8'($random(seed));
    endtask

    task automatic ddr_phase();
        int r;
        for (int i = 0; i < 600; i++) begin
            next_cycle();
            if (i % 100 == 0) begin
                downloading = ~downloading;
            end
            if (ld_take || !(ld_rd || ld_we)) begin
                new_request(ld_rd, ld_we, ld_burstcnt, ld_addr, ld_be);
            end
            if (rot_take || !(rot_rd || rot_we)) begin
                new_request(rot_rd, rot_we, rot_burstcnt, rot_addr, rot_be);
            end
            r              = $random(seed);
            ddr_busy       = (r[1:0] == 2'd0);
            ddr_dout_ready = (owed > 0) && r[2];
            if (ddr_dout_ready) begin
                owed--;
            end
            // Handshake outcome just before the next edge
            #80;
            ld_take  = (ld_rd || ld_we) && !ld_busy;
            rot_take = (rot_rd || rot_we) && !rot_busy;
            if (ddr_rd && !ddr_busy) begin
                owed += int'(ddr_burstcnt);
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        // Live inputs during reset must not leak to the outputs
        status = '1;
        core_mod = '0;
        direct_video = 1'b0;
        db15_word = '0;
        user_in = '1;
        uart_tx = 1'b1;
        game_tx = 1'b1;
        downloading = 1'b0;
        {ld_burstcnt, ld_addr, ld_rd, ld_we, ld_be} = '0;
        {rot_burstcnt, rot_addr, rot_rd, rot_we, rot_be} = '0;
        rot_rd = 1'b1;
        rot_we = 1'b1;
        ddr_busy = 1'b0;
        ddr_dout_ready = 1'b0;
        owed = 0;
        ld_take = 1'b0;
        rot_take = 1'b0;
        repeat (16) @(posedge clk_sys);
        #10;
        reset = 1'b0;
        rot_rd = 1'b0;
        rot_we = 1'b0;
        status_phase();
        user_phase();
        ddr_phase();
        next_cycle();
        if (mr_frame_top_inst.sva_inst.errors == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "assertion failures were recorded");
        end
    end

endmodule

// File: vlog.f
hw/mr_pkg.sv
hw/ddr_port_if.sv
hw/osd_status_decode.sv
hw/user_port_mux.sv
hw/ddr_arbiter.sv
hw/mr_frame_top.sv
tests/mr_frame_sva.sv
tests/mr_frame_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module mr_frame_tb -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
